// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_can_fc -f sim.f
	./obj_dir/Vtb_can_fc > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Result: FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: can_err_event_capture.sv
// input stage: samples the protocol error flags and success strobes, emits one event per cycle
`timescale 1ns/1ps

module can_err_event_capture (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      bit_error,
  input  logic                      stuff_error,
  input  logic                      form_error,
  input  logic                      crc_error,
  input  logic                      ack_error,
  input  logic                      transmitter,
  input  logic                      tx_success,
  input  logic                      rx_success,
  output logic                      ev_valid,
  output logic                      ev_tx,
  output logic                      ok_tx,
  output logic                      ok_rx,
  output can_fc_pkg::can_last_err_u last_err,
  output logic                      last_err_we
);

  logic bit_q;
  logic stuff_q;
  logic form_q;
  logic crc_q;
  logic ack_q;
  logic tx_q;
  logic tx_ok_q;
  logic rx_ok_q;
  logic ack_qual;
  logic any_err;
  logic [2:0] code;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_q   <= 1'b0;
      stuff_q <= 1'b0;
      form_q  <= 1'b0;
      crc_q   <= 1'b0;
      ack_q   <= 1'b0;
      tx_q    <= 1'b0;
      tx_ok_q <= 1'b0;
      rx_ok_q <= 1'b0;
    end else begin
      bit_q   <= bit_error;
      stuff_q <= stuff_error;
      form_q  <= form_error;
      crc_q   <= crc_error;
      ack_q   <= ack_error;
      tx_q    <= transmitter;
      tx_ok_q <= tx_success;
      rx_ok_q <= rx_success;
    end
  end

  // missing ack is only our fault when we sent the frame
  assign ack_qual = ack_q & tx_q;
  assign any_err  = bit_q | stuff_q | form_q | crc_q | ack_qual;

  // bit > stuff > form > crc > ack
  always_comb begin
    code = can_fc_pkg::ERR_NONE;
    if (bit_q) begin
      code = can_fc_pkg::ERR_BIT;
    end else if (stuff_q) begin
      code = can_fc_pkg::ERR_STUFF;
    end else if (form_q) begin
      code = can_fc_pkg::ERR_FORM;
    end else if (crc_q) begin
      code = can_fc_pkg::ERR_CRC;
    end else if (ack_qual) begin
      code = can_fc_pkg::ERR_ACK;
    end
  end

  assign ev_valid = any_err;
  assign ev_tx    = tx_q;
  // an error in the same cycle swallows the success
  assign ok_tx    = tx_ok_q & ~any_err;
  assign ok_rx    = rx_ok_q & ~any_err;

  // overrun is left to the register block, which knows the stored state
  always_comb begin
    last_err                    = '0;
    last_err.fields.valid       = any_err;
    last_err.fields.transmitter = tx_q;
    last_err.fields.code        = code;
  end

  assign last_err_we = any_err;

endmodule

// File: can_fault_confinement.sv
// transmit and receive error counters, confinement state and bus-off recovery
`timescale 1ns/1ps

module can_fault_confinement (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              ev_valid,
  input  logic                              ev_tx,
  input  logic                              ok_tx,
  input  logic                              ok_rx,
  input  logic                              idle_11,
  output logic [can_fc_pkg::TEC_W-1:0]      tec,
  output logic [can_fc_pkg::REC_W-1:0]      rec,
  output logic                              warning,
  output logic                              error_passive,
  output logic                              bus_off
);

  logic [can_fc_pkg::TEC_W-1:0] tec_sum;
  logic [can_fc_pkg::TEC_W-1:0] tec_d;
  logic [can_fc_pkg::REC_W-1:0] rec_d;
  logic [can_fc_pkg::TEC_W-1:0] rec_ext;
  logic [can_fc_pkg::RCV_W-1:0] rcv_cnt;
  logic [can_fc_pkg::RCV_W-1:0] rcv_cnt_d;
  logic                         bus_off_d;
  logic                         recovered;

  // cannot wrap, TEC is at most 255 outside bus-off
  assign tec_sum   = tec + can_fc_pkg::TX_ERR_INC;
  assign rec_ext   = {1'b0, rec};
  assign recovered = bus_off & idle_11 & (rcv_cnt == can_fc_pkg::RCV_LAST);

  always_comb begin
    tec_d     = tec;
    rec_d     = rec;
    rcv_cnt_d = rcv_cnt;
    bus_off_d = bus_off;

    if (bus_off) begin
      // only recovery runs while bus-off
      if (recovered) begin
        tec_d     = '0;
        rec_d     = '0;
        rcv_cnt_d = '0;
        bus_off_d = 1'b0;
      end else if (idle_11) begin
        rcv_cnt_d = rcv_cnt + 1'b1;
      end
    end else if (ev_valid) begin
      if (ev_tx) begin
        if (tec_sum > can_fc_pkg::BUS_OFF_LIMIT) begin
          tec_d     = can_fc_pkg::TEC_HOLD;
          bus_off_d = 1'b1;
          rcv_cnt_d = '0;
        end else begin
          tec_d = tec_sum;
        end
      end else if (rec != can_fc_pkg::REC_MAX) begin
        rec_d = rec + 1'b1;
      end
    end else begin
      if (ok_tx && tec != '0) begin
        tec_d = tec - 1'b1;
      end
      if (ok_rx) begin
        // leaving error-passive as a receiver snaps back to 120
        if (rec_ext >= can_fc_pkg::PASSIVE_LIMIT) begin
          rec_d = can_fc_pkg::REC_PASSIVE_RESTORE;
        end else if (rec != '0) begin
          rec_d = rec - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tec     <= '0;
      rec     <= '0;
      rcv_cnt <= '0;
      bus_off <= 1'b0;
    end else begin
      tec     <= tec_d;
      rec     <= rec_d;
      rcv_cnt <= rcv_cnt_d;
      bus_off <= bus_off_d;
    end
  end

  // states follow the registered counters, so they move on the same edge
  assign warning = (tec >= can_fc_pkg::WARN_LIMIT) ||
                   (rec_ext >= can_fc_pkg::WARN_LIMIT);

  assign error_passive = (tec >= can_fc_pkg::PASSIVE_LIMIT) ||
                         (rec_ext >= can_fc_pkg::PASSIVE_LIMIT) ||
                         bus_off;

endmodule

// File: can_fc_apb_regs.sv
// APB slave for the confinement unit: status, counters, last error and interrupt registers
`timescale 1ns/1ps

module can_fc_apb_regs (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [4:0]                        paddr,
  input  logic [31:0]                       pwdata,
  input  logic [can_fc_pkg::TEC_W-1:0]      tec,
  input  logic [can_fc_pkg::REC_W-1:0]      rec,
  input  logic                              warning,
  input  logic                              error_passive,
  input  logic                              bus_off,
  input  can_fc_pkg::can_last_err_u         last_err,
  input  logic                              last_err_we,
  output logic [31:0]                       prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic                              irq
);

  can_fc_pkg::can_last_err_u le_q;
  logic [1:0] irq_en;
  logic [1:0] irq_stat;
  logic [1:0] irq_set;
  logic       passive_q;
  logic       bus_off_q;
  logic       access;
  logic       mapped;
  logic       read_only;
  logic       le_rd_clr;
  logic       en_wr;
  logic       stat_wr;

  assign access = psel & penable;

  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    case (paddr)
      can_fc_pkg::REG_STATUS,
      can_fc_pkg::REG_COUNTERS,
      can_fc_pkg::REG_LAST_ERR: read_only = 1'b1;
      can_fc_pkg::REG_IRQ_EN,
      can_fc_pkg::REG_IRQ_STAT: read_only = 1'b0;
      default: mapped = 1'b0;
    endcase
  end

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access & (~mapped | (pwrite & read_only));

  assign le_rd_clr = access & ~pwrite & (paddr == can_fc_pkg::REG_LAST_ERR);
  assign en_wr     = access & pwrite & (paddr == can_fc_pkg::REG_IRQ_EN);
  assign stat_wr   = access & pwrite & (paddr == can_fc_pkg::REG_IRQ_STAT);

  always_comb begin
    prdata = '0;
    case (paddr)
      can_fc_pkg::REG_STATUS:   prdata[2:0] = {bus_off, error_passive, warning};
      can_fc_pkg::REG_COUNTERS: prdata = {8'h00, rec, 7'h00, tec};
      can_fc_pkg::REG_LAST_ERR: prdata[7:0] = le_q.raw;
      can_fc_pkg::REG_IRQ_EN:   prdata[1:0] = irq_en;
      can_fc_pkg::REG_IRQ_STAT: prdata[1:0] = irq_stat;
      default:                  prdata = '0;
    endcase
  end

  // a read in the same cycle as a new error already returned the old byte
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      le_q <= '0;
    end else if (last_err_we) begin
      le_q.raw            <= last_err.raw;
      le_q.fields.valid   <= 1'b1;
      le_q.fields.overrun <= le_q.fields.valid & ~le_rd_clr;
    end else if (le_rd_clr) begin
      le_q.fields.valid   <= 1'b0;
      le_q.fields.overrun <= 1'b0;
    end
  end

  always_comb begin
    irq_set = '0;
    irq_set[can_fc_pkg::IRQ_PASSIVE_BIT] = error_passive & ~passive_q;
    irq_set[can_fc_pkg::IRQ_BUSOFF_BIT]  = bus_off & ~bus_off_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      passive_q <= 1'b0;
      bus_off_q <= 1'b0;
      irq_en    <= '0;
      irq_stat  <= '0;
    end else begin
      passive_q <= error_passive;
      bus_off_q <= bus_off;
      if (en_wr) begin
        irq_en <= pwdata[1:0];
      end
      // new edges win over a write-one-to-clear
      if (stat_wr) begin
        irq_stat <= (irq_stat & ~pwdata[1:0]) | irq_set;
      end else begin
        irq_stat <= irq_stat | irq_set;
      end
    end
  end

  assign irq = |(irq_stat & irq_en);

endmodule

// File: can_fc_assertions.sv
// concurrent checks on the confinement unit top level, bound into every can_fc_top instance
`timescale 1ns/1ps

module can_fc_assertions_chk (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         psel,
  input logic                         penable,
  input logic                         pready,
  input logic                         pslverr,
  input logic                         bus_off,
  input logic                         error_passive,
  input logic [can_fc_pkg::TEC_W-1:0] tec
);

  // zero wait states
  a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
    else $error("pready dropped low");

  a_boff_passive: assert property (@(posedge clk) disable iff (!rst_n)
    bus_off |-> error_passive)
    else $error("bus_off without error_passive");

  // TEC is parked at 256 once bus-off is entered
  a_tec_limit: assert property (@(posedge clk) disable iff (!rst_n)
    tec <= can_fc_pkg::TEC_HOLD)
    else $error("tec above 256");

  a_slverr_access: assert property (@(posedge clk) disable iff (!rst_n)
    !(psel && penable) |-> !pslverr)
    else $error("pslverr outside the access phase");

endmodule

bind can_fc_top can_fc_assertions_chk i_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .psel          (psel),
  .penable       (penable),
  .pready        (pready),
  .pslverr       (pslverr),
  .bus_off       (bus_off),
  .error_passive (error_passive),
  .tec           (tec)
);

// File: can_fc_pkg.sv
// shared constants and the last-error type for the CAN fault-confinement unit, used by scoped name
package can_fc_pkg;

  // counter widths
  localparam int TEC_W = 9;
  localparam int REC_W = 8;
  localparam int RCV_W = 7;

  // counter steps and limits
  localparam logic [TEC_W-1:0] TX_ERR_INC    = TEC_W'(8);
  localparam logic [TEC_W-1:0] WARN_LIMIT    = TEC_W'(96);
  localparam logic [TEC_W-1:0] PASSIVE_LIMIT = TEC_W'(128);
  localparam logic [TEC_W-1:0] BUS_OFF_LIMIT = TEC_W'(255);
  // TEC is parked here once bus-off is entered
  localparam logic [TEC_W-1:0] TEC_HOLD      = TEC_W'(256);
  localparam logic [REC_W-1:0] REC_MAX       = REC_W'(255);
  localparam logic [REC_W-1:0] REC_PASSIVE_RESTORE = REC_W'(120);

  // bus-off recovery, counted in 11-recessive-bit pulses
  localparam int RECOVERY_COUNT = 128;
  localparam logic [RCV_W-1:0] RCV_LAST = RCV_W'(RECOVERY_COUNT - 1);

  // last-error codes
  localparam logic [2:0] ERR_NONE  = 3'd0;
  localparam logic [2:0] ERR_BIT   = 3'd1;
  localparam logic [2:0] ERR_STUFF = 3'd2;
  localparam logic [2:0] ERR_FORM  = 3'd3;
  localparam logic [2:0] ERR_CRC   = 3'd4;
  localparam logic [2:0] ERR_ACK   = 3'd5;

  // APB register map, byte offsets
  localparam logic [4:0] REG_STATUS   = 5'h00;
  localparam logic [4:0] REG_COUNTERS = 5'h04;
  localparam logic [4:0] REG_LAST_ERR = 5'h08;
  localparam logic [4:0] REG_IRQ_EN   = 5'h0C;
  localparam logic [4:0] REG_IRQ_STAT = 5'h10;

  // interrupt status and enable bits
  localparam int IRQ_PASSIVE_BIT = 0;
  localparam int IRQ_BUSOFF_BIT  = 1;

  // one byte, seen either as the APB read value or as decoded fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic       valid;
      logic       overrun;
      logic       transmitter;
      logic [1:0] reserved;
      logic [2:0] code;
    } fields;
  } can_last_err_u;

endpackage

// File: can_fc_top.sv
// top level of the CAN fault-confinement unit; connects capture, counters and APB registers
`timescale 1ns/1ps

module can_fc_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        bit_error,
  input  logic        stuff_error,
  input  logic        form_error,
  input  logic        crc_error,
  input  logic        ack_error,
  input  logic        transmitter,
  input  logic        tx_success,
  input  logic        rx_success,
  input  logic        idle_11,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        irq,
  output logic        bus_off,
  output logic        error_passive
);

  logic                         ev_valid;
  logic                         ev_tx;
  logic                         ok_tx;
  logic                         ok_rx;
  can_fc_pkg::can_last_err_u    last_err;
  logic                         last_err_we;
  logic [can_fc_pkg::TEC_W-1:0] tec;
  logic [can_fc_pkg::REC_W-1:0] rec;
  logic                         warning;

  can_err_event_capture i_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .bit_error   (bit_error),
    .stuff_error (stuff_error),
    .form_error  (form_error),
    .crc_error   (crc_error),
    .ack_error   (ack_error),
    .transmitter (transmitter),
    .tx_success  (tx_success),
    .rx_success  (rx_success),
    .ev_valid    (ev_valid),
    .ev_tx       (ev_tx),
    .ok_tx       (ok_tx),
    .ok_rx       (ok_rx),
    .last_err    (last_err),
    .last_err_we (last_err_we)
  );

  can_fault_confinement i_confine (
    .clk           (clk),
    .rst_n         (rst_n),
    .ev_valid      (ev_valid),
    .ev_tx         (ev_tx),
    .ok_tx         (ok_tx),
    .ok_rx         (ok_rx),
    .idle_11       (idle_11),
    .tec           (tec),
    .rec           (rec),
    .warning       (warning),
    .error_passive (error_passive),
    .bus_off       (bus_off)
  );

  can_fc_apb_regs i_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .tec           (tec),
    .rec           (rec),
    .warning       (warning),
    .error_passive (error_passive),
    .bus_off       (bus_off),
    .last_err      (last_err),
    .last_err_we   (last_err_we),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .irq           (irq)
  );

endmodule

// File: sim.f
can_fc_pkg.sv
can_err_event_capture.sv
can_fault_confinement.sv
can_fc_apb_regs.sv
can_fc_top.sv
can_fc_assertions.sv
tb_can_fc.sv

// File: tb_can_fc.sv
// directed testbench that checks the CAN fault-confinement unit against a counter model
`timescale 1ns/1ps

module tb_can_fc;

  logic clk = 1'b0;
  logic rst_n;
  logic bit_error;
  logic stuff_error;
  logic form_error;
  logic crc_error;
  logic ack_error;
  logic transmitter;
  logic tx_success;
  logic rx_success;
  logic idle_11;
  logic psel;
  logic penable;
  logic pwrite;
  logic [4:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic irq;
  logic bus_off;
  logic error_passive;
  // reference model state
  int m_tec;
  int m_rec;
  int m_idle;
  bit m_boff;
  int errors;
  int test_errs;
  int tests;
  int failed;
  string cur_test;
  logic [31:0] rd;
  logic err;

  always #10 clk = ~clk;

  can_fc_top i_dut (.*);

  task automatic report(string what, logic [31:0] want, logic [31:0] got);
    errors++;
    test_errs++;
    $display("ERR %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, want, got);
  endtask

  task automatic fault(string msg);
    errors++;
    test_errs++;
    $display("test %s: %s", cur_test, msg);
  endtask

  task automatic do_reset(string name);
    cur_test = name;
    test_errs = 0;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    m_tec = 0;
    m_rec = 0;
    m_idle = 0;
    m_boff = 1'b0;
  endtask

  task automatic end_test();
    tests++;
    if (test_errs == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      failed++;
      $display("test %s: %0d errors", cur_test, test_errs);
    end
  endtask

  // one APB transfer leaving read data in rd and pslverr in err
  task automatic apb(logic wr, logic [4:0] addr, logic [31:0] data);
    int n;
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;
    n = 0;
    @(negedge clk);
    while (pready !== 1'b1 && n < 16) begin
      @(negedge clk);
      n++;
    end
    if (pready !== 1'b1) fault("pready never came during an APB access");
    rd = prdata;
    err = pslverr;
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  // flags {bit, stuff, form, crc, ack} held for one cycle
  task automatic pulse(logic [4:0] flags, logic tx, logic ok_t, logic ok_r);
    @(posedge clk);
    {bit_error, stuff_error, form_error, crc_error, ack_error} <= flags;
    transmitter <= tx;
    tx_success <= ok_t;
    rx_success <= ok_r;
    @(posedge clk);
    {bit_error, stuff_error, form_error, crc_error, ack_error} <= 5'b0;
    {transmitter, tx_success, rx_success} <= 3'b0;
    if (!m_boff) begin
      if (|flags[4:1] || (flags[0] && tx)) begin
        if (tx) begin
          m_tec += 8;
          if (m_tec > 255) begin
            m_tec = 256;
            m_boff = 1'b1;
          end
        end else if (m_rec < 255) begin
          m_rec++;
        end
      end else begin
        if (ok_t && m_tec > 0) m_tec--;
        if (ok_r) m_rec = (m_rec > 127) ? 120 : ((m_rec > 0) ? m_rec - 1 : 0);
      end
    end
  endtask

  task automatic idle_pulse();
    @(posedge clk);
    idle_11 <= 1'b1;
    @(posedge clk);
    idle_11 <= 1'b0;
    if (m_boff) begin
      m_idle++;
      if (m_idle == 128) begin
        m_boff = 1'b0;
        m_tec = 0;
        m_rec = 0;
        m_idle = 0;
      end
    end
  endtask

  function automatic logic [31:0] le_byte(logic ov, logic tx, logic [2:0] code);
    return {24'h0, 1'b1, ov, tx, 2'b00, code};
  endfunction

  task automatic check_regs();
    logic [31:0] want;
    apb(1'b0, can_fc_pkg::REG_COUNTERS, '0);
    want = {8'h00, 8'(m_rec), 7'h00, 9'(m_tec)};
    if (rd !== want) report("COUNTERS", want, rd);
    if (err !== 1'b0) report("pslverr on COUNTERS read", 32'd0, 32'(err));
    apb(1'b0, can_fc_pkg::REG_STATUS, '0);
    want = {29'd0, m_boff, (m_tec >= 128 || m_rec >= 128 || m_boff),
            (m_tec >= 96 || m_rec >= 96)};
    if (rd !== want) report("STATUS", want, rd);
    @(negedge clk);
    if (bus_off !== want[2]) report("bus_off", 32'(want[2]), 32'(bus_off));
    if (error_passive !== want[1]) report("error_passive", 32'(want[1]), 32'(error_passive));
  endtask

  task automatic after_reset();
    do_reset("reset");
    check_regs();
    apb(1'b0, can_fc_pkg::REG_LAST_ERR, '0);
    if (rd !== 32'd0) report("LAST_ERR", 32'd0, rd);
    if (irq !== 1'b0) report("irq", 32'd0, 32'(irq));
    apb(1'b1, can_fc_pkg::REG_COUNTERS, 32'h00ff_01ff);
    if (err !== 1'b1) report("pslverr on COUNTERS write", 32'd1, 32'(err));
    apb(1'b0, 5'h14, '0);
    if (err !== 1'b1) report("pslverr on unmapped read", 32'd1, 32'(err));
    check_regs();
    end_test();
  endtask

  task automatic random_counting();
    int op;
    logic [4:0] flag;
    do_reset("random_mix");
    pulse(5'b0, 1'b1, 1'b1, 1'b1);
    check_regs();
    repeat (40) begin
      op = $urandom % 4;
      flag = 5'b10000 >> ($urandom % 4);
      // keep clear of bus-off here
      if (op == 0 && m_tec > 200) op = 2;
      case (op)
        0: pulse(flag, 1'b1, 1'b0, 1'b0);
        1: pulse(flag, 1'b0, 1'b0, 1'b0);
        2: pulse(5'b0, 1'b1, 1'b1, 1'b0);
        default: pulse(5'b0, 1'b0, 1'b0, 1'b1);
      endcase
      check_regs();
    end
    while (m_rec < 130) pulse(5'b00100, 1'b0, 1'b0, 1'b0);
    check_regs();
    pulse(5'b0, 1'b0, 1'b0, 1'b1);
    check_regs();
    end_test();
  endtask

  task automatic collisions();
    do_reset("collisions");
    // bit and crc together plus a success that must be dropped
    pulse(5'b10010, 1'b1, 1'b1, 1'b0);
    check_regs();
    apb(1'b0, can_fc_pkg::REG_LAST_ERR, '0);
    if (rd !== le_byte(1'b0, 1'b1, can_fc_pkg::ERR_BIT)) begin
      report("LAST_ERR", le_byte(1'b0, 1'b1, can_fc_pkg::ERR_BIT), rd);
    end
    pulse(5'b01100, 1'b0, 1'b0, 1'b1);
    pulse(5'b00010, 1'b1, 1'b0, 1'b0);
    check_regs();
    apb(1'b0, can_fc_pkg::REG_LAST_ERR, '0);
    if (rd !== le_byte(1'b1, 1'b1, can_fc_pkg::ERR_CRC)) begin
      report("LAST_ERR overrun", le_byte(1'b1, 1'b1, can_fc_pkg::ERR_CRC), rd);
    end
    apb(1'b0, can_fc_pkg::REG_LAST_ERR, '0);
    if (rd[7:6] !== 2'b00) report("LAST_ERR after read", 32'd0, 32'(rd[7:6]));
    // ack error as receiver is not ours
    pulse(5'b00001, 1'b0, 1'b0, 1'b0);
    check_regs();
    apb(1'b0, can_fc_pkg::REG_LAST_ERR, '0);
    if (rd[7] !== 1'b0) report("LAST_ERR valid", 32'd0, 32'(rd[7]));
    end_test();
  endtask

  task automatic passive_interrupt();
    int n;
    do_reset("passive_irq");
    apb(1'b1, can_fc_pkg::REG_IRQ_EN, 32'd1 << can_fc_pkg::IRQ_PASSIVE_BIT);
    while (m_rec < 128) pulse(5'b10000, 1'b0, 1'b0, 1'b0);
    check_regs();
    n = 0;
    while (irq !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (irq !== 1'b1) fault("timed out waiting for irq after error-passive");
    apb(1'b1, can_fc_pkg::REG_IRQ_STAT, 32'd1 << can_fc_pkg::IRQ_PASSIVE_BIT);
    @(negedge clk);
    if (irq !== 1'b0) report("irq after clear", 32'd0, 32'(irq));
    apb(1'b0, can_fc_pkg::REG_IRQ_STAT, '0);
    if (rd !== 32'd0) report("IRQ_STAT", 32'd0, rd);
    end_test();
  endtask

  task automatic bus_off_recovery();
    int n;
    do_reset("bus_off");
    repeat (32) pulse(5'b01000, 1'b1, 1'b0, 1'b0);
    n = 0;
    while (bus_off !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (bus_off !== 1'b1) fault("timed out waiting for bus_off");
    check_regs();
    // no enables after reset so the status bits stay masked
    if (irq !== 1'b0) report("irq masked", 32'd0, 32'(irq));
    pulse(5'b10000, 1'b1, 1'b0, 1'b0);
    pulse(5'b10000, 1'b0, 1'b0, 1'b1);
    pulse(5'b0, 1'b1, 1'b1, 1'b1);
    check_regs();
    repeat (127) idle_pulse();
    check_regs();
    idle_pulse();
    n = 0;
    while (bus_off !== 1'b0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (bus_off !== 1'b0) fault("bus_off still high after 128 idle pulses");
    check_regs();
    end_test();
  endtask

  initial begin
    void'($urandom(38));
    rst_n = 1'b0;
    {bit_error, stuff_error, form_error, crc_error, ack_error} = '0;
    {transmitter, tx_success, rx_success, idle_11} = '0;
    {psel, penable, pwrite} = '0;
    paddr = '0;
    pwdata = '0;
    after_reset();
    random_counting();
    collisions();
    passive_interrupt();
    bus_off_recovery();
    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
